// ==== common/decode_defs.svh ====
// Width and count macros for the RV32I decode stage
// REG_AW must cover NUM_REGS; only the 32-register layout is supported
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Data word width
`define XLEN 32

// Integer register count, x0 included
`define NUM_REGS 32

// Register index width
`define REG_AW 5

`endif

// ==== common/decode_pkg.sv ====
// Types shared by the RV32I decode stage
// Enum value 0 of each select is the idle state of a bubble
`default_nettype none

`include "decode_defs.svh"

package decode_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;

  // Base opcodes kept in this stage
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } aluop_t;

  typedef enum logic [1:0] {
    A_RS1   = 2'd0,
    A_IMM_S = 2'd1,
    A_PC    = 2'd2,
    A_ZERO  = 2'd3
  } alu_a_sel_t;

  typedef enum logic [1:0] {
    B_RS1       = 2'd0,
    B_RS2       = 2'd1,
    B_IMM_SHAMT = 2'd2,
    B_IMM_U     = 2'd3
  } alu_b_sel_t;

  typedef enum logic [2:0] {
    W_ALU   = 3'd0,
    W_PC4   = 3'd1,
    W_IMM_U = 3'd2
  } w_sel_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t pc4;
  } fetch_t;

  typedef struct packed {
    logic pc_en;
    logic stall;
    logic flush;
  } hazard_t;

  // Write-back port into the register file
  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    word_t     wdata;
  } wb_t;

  typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    logic       imm_shamt_sel;
    aluop_t     aluop;
    w_sel_t     w_sel;
    logic       wen;
    logic       dwen;
    logic       dren;
    logic [2:0] load_type;
    logic       jump;
    logic       j_sel;
    logic       branch;
    logic [2:0] branch_type;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    word_t imm_I;
    word_t imm_S;
    word_t imm_SB;
    word_t imm_UJ;
    word_t imm_U;
    word_t shamt;
  } imm_t;

  typedef struct packed {
    aluop_t     aluop;
    word_t      port_a;
    word_t      port_b;
    word_t      rs1_data;
    word_t      rs2_data;
    reg_addr_t  reg_rs1;
    reg_addr_t  reg_rs2;
    reg_addr_t  reg_rd;
    word_t      reg_file_wdata;
    w_sel_t     w_sel;
    logic       wen;
    logic       dwen;
    logic       dren;
    logic [2:0] load_type;
    logic       jump_instr;
    word_t      j_base;
    word_t      j_offset;
    logic       j_sel;
    word_t      br_imm_sb;
    logic [2:0] branch_type;
    logic       branch_instr;
    word_t      pc;
    word_t      pc4;
    logic       illegal_insn;
    word_t      instr;
  } id_ex_t;

endpackage

`default_nettype wire

// ==== decode/control_decoder.sv ====
// Main decoder for the RV32I base opcodes; no CSR, system or fence support
// Register fields pass through raw even when an opcode does not use them
`timescale 1ns/1ps
`default_nettype none

module control_decoder
  import decode_pkg::*;
(
  input  word_t instr,
  output ctrl_t ctrl
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       bit30;
  aluop_t     reg_aluop;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign bit30  = instr[30];

  // funct3 to ALU op, bit 30 picks SUB and SRA
  always_comb begin
    case (funct3)
      3'b000:  reg_aluop = bit30 ? ALU_SUB : ALU_ADD;
      3'b001:  reg_aluop = ALU_SLL;
      3'b010:  reg_aluop = ALU_SLT;
      3'b011:  reg_aluop = ALU_SLTU;
      3'b100:  reg_aluop = ALU_XOR;
      3'b101:  reg_aluop = bit30 ? ALU_SRA : ALU_SRL;
      3'b110:  reg_aluop = ALU_OR;
      default: reg_aluop = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl             = '0;
    ctrl.rs1         = instr[19:15];
    ctrl.rs2         = instr[24:20];
    ctrl.rd          = instr[11:7];
    ctrl.load_type   = funct3;
    ctrl.branch_type = funct3;

    case (opcode)
      LUI: begin
        ctrl.w_sel = W_IMM_U;
        ctrl.wen   = 1'b1;
      end
      AUIPC: begin
        ctrl.alu_a_sel = A_PC;
        ctrl.alu_b_sel = B_IMM_U;
        ctrl.wen       = 1'b1;
      end
      JAL: begin
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
        ctrl.w_sel = W_PC4;
        ctrl.wen   = 1'b1;
      end
      JALR: begin
        // Base comes from rs1, so j_sel stays low
        ctrl.jump  = 1'b1;
        ctrl.w_sel = W_PC4;
        ctrl.wen   = 1'b1;
      end
      BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.alu_a_sel = A_RS1;
        ctrl.alu_b_sel = B_RS2;
      end
      LOAD: begin
        ctrl.dren      = 1'b1;
        ctrl.alu_a_sel = A_RS1;
        ctrl.alu_b_sel = B_IMM_SHAMT;
        ctrl.wen       = 1'b1;
      end
      STORE: begin
        // Address is rs1 + imm_S with the operands swapped
        ctrl.dwen      = 1'b1;
        ctrl.alu_a_sel = A_IMM_S;
        ctrl.alu_b_sel = B_RS1;
      end
      OP_IMM: begin
        ctrl.alu_a_sel     = A_RS1;
        ctrl.alu_b_sel     = B_IMM_SHAMT;
        ctrl.imm_shamt_sel = (funct3 == 3'b001) || (funct3 == 3'b101);
        ctrl.aluop         = (funct3 == 3'b000) ? ALU_ADD : reg_aluop;
        ctrl.wen           = 1'b1;
      end
      OP: begin
        ctrl.alu_a_sel = A_RS1;
        ctrl.alu_b_sel = B_RS2;
        ctrl.aluop     = reg_aluop;
        ctrl.wen       = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== decode/imm_gen.sv ====
// Immediate builder for the RV32I formats; all outputs are full words
`timescale 1ns/1ps
`default_nettype none

module imm_gen
  import decode_pkg::*;
(
  input  word_t instr,
  output imm_t  imm
);

  logic sign;

  assign sign = instr[31];

  // Loads, JALR and ALU immediates
  assign imm.imm_I = {{20{sign}}, instr[31:20]};

  // Store offset split across two fields
  assign imm.imm_S = {{20{sign}}, instr[31:25], instr[11:7]};

  // Branch offset, bit 0 always zero
  assign imm.imm_SB = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};

  // JAL offset
  assign imm.imm_UJ = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};

  // LUI and AUIPC upper immediate
  assign imm.imm_U = {instr[31:12], 12'b0};

  // Shift amount, zero-extended
  assign imm.shamt = word_t'(instr[24:20]);

endmodule

`default_nettype wire

// ==== decode/operand_mux.sv ====
// Operand, write-back data and jump target selection for the decode stage
// A_ZERO and any unused w_sel produce zero
`timescale 1ns/1ps
`default_nettype none

module operand_mux
  import decode_pkg::*;
(
  input  ctrl_t ctrl,
  input  imm_t  imm,
  input  word_t rs1_data,
  input  word_t rs2_data,
  input  word_t pc,
  input  word_t pc4,
  output word_t port_a,
  output word_t port_b,
  output word_t w_data,
  output word_t j_base,
  output word_t j_offset
);

  word_t imm_or_shamt;

  // Shifts by immediate use the shamt field instead of imm_I
  assign imm_or_shamt = ctrl.imm_shamt_sel ? imm.shamt : imm.imm_I;

  always_comb begin
    case (ctrl.alu_a_sel)
      A_RS1:   port_a = rs1_data;
      A_IMM_S: port_a = imm.imm_S;
      A_PC:    port_a = pc;
      default: port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_b_sel)
      B_RS1:       port_b = rs1_data;
      B_RS2:       port_b = rs2_data;
      B_IMM_SHAMT: port_b = imm_or_shamt;
      default:     port_b = imm.imm_U;
    endcase
  end

  // Early write-back value; ALU results are filled in later stages
  always_comb begin
    case (ctrl.w_sel)
      W_PC4:   w_data = pc4;
      W_IMM_U: w_data = imm.imm_U;
      default: w_data = '0;
    endcase
  end

  // JAL is pc relative, JALR is rs1 relative
  assign j_base   = ctrl.j_sel ? pc : rs1_data;
  assign j_offset = ctrl.j_sel ? imm.imm_UJ : imm.imm_I;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// Integer register file with two async reads and one sync write
// No write-to-read bypass; a write is seen only after its clock edge
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module reg_file
  import decode_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  wb_t       wb,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [`NUM_REGS];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wen && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.wdata;
    end
  end

  // x0 keeps its reset value because writes to it are dropped
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/id_ex_reg.sv ====
// ID/EX pipeline register; halt and flush insert an all-zero bubble
// A stall with pc_en also bubbles, pc_en low without halt holds
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
  import decode_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    halt,
  input  hazard_t hz,
  input  id_ex_t  next,
  output id_ex_t  id_ex
);

  logic bubble;
  logic load;

  // Bubble wins over load
  assign bubble = halt || ((hz.flush || hz.stall) && hz.pc_en);
  assign load   = hz.pc_en && !hz.stall;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex <= '0;
    end else if (bubble) begin
      id_ex <= '0;
    end else if (load) begin
      id_ex <= next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/decode_top.sv ====
// Decode stage of a five-stage RV32I pipeline with one cycle of latency
// Write-back comes from outside; hazard levels act only on the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decode_top
  import decode_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    halt,
  input  fetch_t  fetch,
  input  hazard_t hz,
  input  wb_t     wb,
  output id_ex_t  id_ex
);

  ctrl_t  ctrl;
  imm_t   imm;
  word_t  rs1_data;
  word_t  rs2_data;
  word_t  port_a;
  word_t  port_b;
  word_t  w_data;
  word_t  j_base;
  word_t  j_offset;
  id_ex_t next;

  control_decoder i_control_decoder (
    .instr (fetch.instr),
    .ctrl  (ctrl)
  );

  imm_gen i_imm_gen (
    .instr (fetch.instr),
    .imm   (imm)
  );

  reg_file i_reg_file (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .wb       (wb),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  operand_mux i_operand_mux (
    .ctrl     (ctrl),
    .imm      (imm),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (fetch.pc),
    .pc4      (fetch.pc4),
    .port_a   (port_a),
    .port_b   (port_b),
    .w_data   (w_data),
    .j_base   (j_base),
    .j_offset (j_offset)
  );

  // Next ID/EX contents
  always_comb begin
    next.aluop          = ctrl.aluop;
    next.port_a         = port_a;
    next.port_b         = port_b;
    next.rs1_data       = rs1_data;
    next.rs2_data       = rs2_data;
    next.reg_rs1        = ctrl.rs1;
    next.reg_rs2        = ctrl.rs2;
    next.reg_rd         = ctrl.rd;
    next.reg_file_wdata = w_data;
    next.w_sel          = ctrl.w_sel;
    next.wen            = ctrl.wen;
    next.dwen           = ctrl.dwen;
    next.dren           = ctrl.dren;
    next.load_type      = ctrl.load_type;
    next.jump_instr     = ctrl.jump;
    next.j_base         = j_base;
    next.j_offset       = j_offset;
    next.j_sel          = ctrl.j_sel;
    next.br_imm_sb      = imm.imm_SB;
    next.branch_type    = ctrl.branch_type;
    next.branch_instr   = ctrl.branch;
    next.pc             = fetch.pc;
    next.pc4            = fetch.pc4;
    next.illegal_insn   = ctrl.illegal;
    next.instr          = fetch.instr;
  end

  id_ex_reg i_id_ex_reg (
    .CLK   (CLK),
    .nRST  (nRST),
    .halt  (halt),
    .hz    (hz),
    .next  (next),
    .id_ex (id_ex)
  );

endmodule

`default_nettype wire

// ==== sim/decode_checker.sv ====
// Concurrent checks on the ID/EX register, bound into every id_ex_reg
// Checks are idle while nRST is low
`timescale 1ns/1ps
`default_nettype none

module decode_checker
  import decode_pkg::*;
(
  input logic    CLK,
  input logic    nRST,
  input logic    halt,
  input hazard_t hz,
  input id_ex_t  id_ex
);

  // No write or memory enable survives a halt
  halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> !(id_ex.wen || id_ex.dwen || id_ex.dren))
    else $error("write or memory enable active in the cycle after halt");

  // Halt leaves a full bubble
  halt_bubble: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> (id_ex == '0))
    else $error("id_ex not cleared after halt");

  // Without pc_en, halt or flush the register holds
  hold_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (!hz.pc_en && !halt && !hz.flush) |=> $stable(id_ex))
    else $error("id_ex changed while the stage was held");

endmodule

bind id_ex_reg decode_checker i_decode_checker (
  .CLK   (CLK),
  .nRST  (nRST),
  .halt  (halt),
  .hz    (hz),
  .id_ex (id_ex)
);

`default_nettype wire

// ==== sim/tb_clock.sv ====
// Clock and reset source for the testbench, 4 ns period
// nRST is released 1 ns after the eighth rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic CLK,
  output logic nRST
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 8;

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/decode_tb.sv ====
// Random-stimulus testbench for the decode stage against a shadow register model
// Inputs change 1 ns after each rising edge and id_ex is compared at that same point
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module decode_tb
  import decode_pkg::*;
();

  localparam int PER_OP_CYCLES  = 24;
  localparam int ILLEGAL_CYCLES = 40;
  localparam int HAZARD_CYCLES  = 200;
  localparam int RANDOM_CYCLES  = 400;
  localparam int TOTAL_CYCLES   = 8 + 2 * `NUM_REGS + 9 * PER_OP_CYCLES + ILLEGAL_CYCLES
                                  + HAZARD_CYCLES + RANDOM_CYCLES;
  localparam int TIMEOUT_CYCLES = TOTAL_CYCLES + 100;

  localparam opcode_t KEPT_OPS [9] = '{LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, OP_IMM, OP};
  localparam hazard_t RUN = '{pc_en: 1'b1, stall: 1'b0, flush: 1'b0};

  logic    CLK;
  logic    nRST;
  logic    halt;
  fetch_t  fetch;
  hazard_t hz;
  wb_t     wb;
  id_ex_t  id_ex;

  word_t   shadow [`NUM_REGS];
  id_ex_t  expected;
  int      checks;
  int      errors;
  int      cycle_count;

  tb_clock i_tb_clock (
    .CLK  (CLK),
    .nRST (nRST)
  );

  decode_top i_decode_top (
    .CLK   (CLK),
    .nRST  (nRST),
    .halt  (halt),
    .fetch (fetch),
    .hz    (hz),
    .wb    (wb),
    .id_ex (id_ex)
  );

  // alt is instr bit 30 where it counts
  function automatic aluop_t alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Reference decode from the RV32I formats and the shadow registers
  function automatic id_ex_t expect_decode(input fetch_t f);
    id_ex_t     e;
    logic [2:0] f3;
    word_t      imm_i;
    word_t      imm_u;
    e = '0;
    f3 = f.instr[14:12];
    imm_i = word_t'($signed(f.instr) >>> 20);
    imm_u = {f.instr[31:12], 12'b0};
    e.instr = f.instr;
    e.pc = f.pc;
    e.pc4 = f.pc4;
    e.reg_rs1 = f.instr[19:15];
    e.reg_rs2 = f.instr[24:20];
    e.reg_rd = f.instr[11:7];
    e.rs1_data = shadow[e.reg_rs1];
    e.rs2_data = shadow[e.reg_rs2];
    e.load_type = f3;
    e.branch_type = f3;
    e.br_imm_sb = {{20{f.instr[31]}}, f.instr[7], f.instr[30:25], f.instr[11:8], 1'b0};
    // Idle selects pass rs1 to both ports and rs1 + imm_I to the jump fields
    e.port_a = e.rs1_data;
    e.port_b = e.rs1_data;
    e.j_base = e.rs1_data;
    e.j_offset = imm_i;
    e.aluop = ALU_ADD;
    case (f.instr[6:0])
      LUI: begin
        e.w_sel = W_IMM_U;
        e.reg_file_wdata = imm_u;
        e.wen = 1'b1;
      end
      AUIPC: begin
        e.port_a = f.pc;
        e.port_b = imm_u;
        e.wen = 1'b1;
      end
      JAL, JALR: begin
        e.jump_instr = 1'b1;
        e.w_sel = W_PC4;
        e.reg_file_wdata = f.pc4;
        e.wen = 1'b1;
        if (f.instr[3]) begin
          e.j_sel = 1'b1;
          e.j_base = f.pc;
          e.j_offset = {{12{f.instr[31]}}, f.instr[19:12], f.instr[20], f.instr[30:21], 1'b0};
        end
      end
      BRANCH: begin
        e.branch_instr = 1'b1;
        e.port_b = e.rs2_data;
      end
      LOAD: begin
        e.dren = 1'b1;
        e.port_b = imm_i;
        e.wen = 1'b1;
      end
      STORE: begin
        e.dwen = 1'b1;
        e.port_a = {imm_i[31:5], f.instr[11:7]};
      end
      OP_IMM: begin
        e.aluop = alu_of(f3, f.instr[30] && (f3 == 3'd5));
        e.port_b = (f3[1:0] == 2'b01) ? {27'b0, f.instr[24:20]} : imm_i;
        e.wen = 1'b1;
      end
      OP: begin
        e.aluop = alu_of(f3, f.instr[30]);
        e.port_b = e.rs2_data;
        e.wen = 1'b1;
      end
      default: e.illegal_insn = 1'b1;
    endcase
    return e;
  endfunction

  function automatic word_t random_instr(input logic [6:0] op);
    word_t instr;
    instr = $urandom;
    instr[6:0] = op;
    return instr;
  endfunction

  function automatic word_t random_kept_instr();
    logic [3:0] k;
    k = 4'($urandom % 9);
    return random_instr(KEPT_OPS[k]);
  endfunction

  function automatic word_t illegal_instr();
    logic [6:0] op;
    op = 7'($urandom);
    while (op inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, OP_IMM, OP}) begin
      op = 7'($urandom);
    end
    return random_instr(op);
  endfunction

  function automatic hazard_t random_hazard();
    hazard_t h;
    h.pc_en = ($urandom % 4) != 0;
    h.stall = ($urandom % 8) == 0;
    h.flush = ($urandom % 8) == 0;
    return h;
  endfunction

  function automatic wb_t random_wb();
    wb_t w;
    w.wen = ($urandom % 2) == 1;
    w.rd = reg_addr_t'($urandom);
    w.wdata = $urandom;
    return w;
  endfunction

  task automatic check_field(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_outputs();
    check_field("aluop", word_t'(id_ex.aluop), word_t'(expected.aluop));
    check_field("port_a", id_ex.port_a, expected.port_a);
    check_field("port_b", id_ex.port_b, expected.port_b);
    check_field("rs1_data", id_ex.rs1_data, expected.rs1_data);
    check_field("rs2_data", id_ex.rs2_data, expected.rs2_data);
    check_field("reg_file_wdata", id_ex.reg_file_wdata, expected.reg_file_wdata);
    check_field("j_base", id_ex.j_base, expected.j_base);
    check_field("j_offset", id_ex.j_offset, expected.j_offset);
    check_field("jump,branch,wen,dwen,dren,illegal",
      word_t'({id_ex.jump_instr, id_ex.branch_instr, id_ex.wen, id_ex.dwen, id_ex.dren,
               id_ex.illegal_insn}),
      word_t'({expected.jump_instr, expected.branch_instr, expected.wen, expected.dwen,
               expected.dren, expected.illegal_insn}));
    checks++;
    assert (id_ex === expected) else begin
      $display("mismatch at %0t: id_ex got %h expected %h", $time, id_ex, expected);
      errors++;
    end
  endtask

  // One cycle entered and left 1 ns after a rising edge
  task automatic step(input word_t instr, input hazard_t h, input logic hlt, input wb_t w);
    fetch_t f;
    id_ex_t nxt;
    f.instr = instr;
    f.pc = $urandom;
    f.pc[1:0] = 2'b00;
    f.pc4 = f.pc + 32'd4;
    nxt = expect_decode(f);
    fetch = f;
    hz = h;
    halt = hlt;
    wb = w;
    @(posedge CLK);
    #1;
    // Bubble first, then load, otherwise hold
    if (hlt || ((h.flush || h.stall) && h.pc_en)) begin
      expected = '0;
    end else if (h.pc_en && !h.stall) begin
      expected = nxt;
    end
    if (w.wen && (w.rd != '0)) begin
      shadow[w.rd] = w.wdata;
    end
    compare_outputs();
  endtask

  task automatic report(input string name, input int cycles, input int errors_before);
    $display("test %s: %0d cycles, %0d errors", name, cycles, errors - errors_before);
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int    mark;
    wb_t   w;
    word_t instr;
    void'($urandom(31503));
    halt = 1'b0;
    fetch = '0;
    hz = '0;
    wb = '0;
    expected = '0;
    checks = 0;
    errors = 0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    wait (nRST === 1'b1);

    mark = errors;
    compare_outputs();
    report("reset", 0, mark);

    // Every register written under halt with x0 included
    mark = errors;
    for (int i = 0; i < `NUM_REGS; i++) begin
      w.wen = 1'b1;
      w.rd = reg_addr_t'(i);
      w.wdata = $urandom;
      step(random_kept_instr(), RUN, 1'b1, w);
    end
    report("preload", `NUM_REGS, mark);

    mark = errors;
    for (int i = 0; i < `NUM_REGS; i++) begin
      instr = random_instr(OP);
      instr[19:15] = reg_addr_t'(i);
      instr[24:20] = reg_addr_t'(`NUM_REGS - 1 - i);
      step(instr, RUN, 1'b0, '0);
    end
    report("readback", `NUM_REGS, mark);

    mark = errors;
    for (int j = 0; j < 9; j++) begin
      for (int n = 0; n < PER_OP_CYCLES; n++) begin
        step(random_instr(KEPT_OPS[4'(j)]), RUN, 1'b0, '0);
      end
    end
    report("opcodes", 9 * PER_OP_CYCLES, mark);

    mark = errors;
    for (int n = 0; n < ILLEGAL_CYCLES; n++) begin
      step(illegal_instr(), RUN, 1'b0, '0);
    end
    report("illegal", ILLEGAL_CYCLES, mark);

    mark = errors;
    for (int n = 0; n < HAZARD_CYCLES; n++) begin
      step(random_kept_instr(), random_hazard(), ($urandom % 8) == 0, random_wb());
    end
    report("hazards", HAZARD_CYCLES, mark);

    mark = errors;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      instr = (($urandom % 16) == 0) ? illegal_instr() : random_kept_instr();
      step(instr, random_hazard(), ($urandom % 16) == 0, random_wb());
    end
    report("random", RANDOM_CYCLES, mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/decode_pkg.sv
decode/control_decoder.sv
decode/imm_gen.sv
decode/operand_mux.sv
rtl/reg_file.sv
rtl/id_ex_reg.sv
rtl/decode_top.sv
sim/decode_checker.sv
sim/tb_clock.sv
sim/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module decode_tb -o decode_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/decode_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
